/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run tb_inst_buffer, check sim.log"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -j 0 -f files.f \
	  --top-module tb_inst_buffer --Mdir obj_dir -o sim_tb
	-./obj_dir/sim_tb > sim.log 2>&1
	@cat sim.log
	@if grep -q "Verification failed" sim.log; then exit 1; fi
	@grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* files.f */
+incdir+include
hdl/ib_isa_pkg.sv
hdl/ib_disp_pkg.sv
hdl/inst_fetch_queue.sv
hdl/inst_slot_decoder.sv
hdl/dispatch_group_picker.sv
hdl/inst_buffer_top.sv
sim/inst_buffer_properties.sv
sim/tb_inst_buffer.sv

/* hdl/dispatch_group_picker.sv */
`timescale 1ns/1ps

`include "ib_defines.svh"

module dispatch_group_picker (
  input  logic                                         i_clk,
  input  logic                                         i_reset_n,
  input  logic                                         i_flush_valid,
  input  logic                                         i_head_valid,
  input  ib_disp_pkg::pc_t                             i_head_pc,
  input  ib_isa_pkg::inst_word_t [`IB_BLOCK_WORDS-1:0] i_head_block,
  input  ib_isa_pkg::inst_cat_t                        i_cat     [`IB_BLOCK_WORDS],
  input  ib_disp_pkg::slot_mask_t                      i_rd_valid,
  input  ib_isa_pkg::reg_idx_t                         i_rd_idx  [`IB_BLOCK_WORDS],
  input  ib_disp_pkg::slot_mask_t                      i_rs1_valid,
  input  ib_isa_pkg::reg_idx_t                         i_rs1_idx [`IB_BLOCK_WORDS],
  input  ib_disp_pkg::slot_mask_t                      i_rs2_valid,
  input  ib_isa_pkg::reg_idx_t                         i_rs2_idx [`IB_BLOCK_WORDS],
  input  logic                                         i_disp_ready,
  output logic                                         o_pop,
  output logic                                         o_disp_valid,
  output ib_disp_pkg::slot_mask_t                      o_disp_slot_valid,
  output ib_isa_pkg::inst_word_t                       o_disp_inst    [`IB_BLOCK_WORDS],
  output ib_disp_pkg::pc_t                             o_disp_pc      [`IB_BLOCK_WORDS],
  output ib_isa_pkg::inst_cat_t                        o_disp_cat     [`IB_BLOCK_WORDS],
  output ib_disp_pkg::slot_mask_t                      o_disp_rd_valid,
  output ib_isa_pkg::reg_idx_t                         o_disp_rd_idx  [`IB_BLOCK_WORDS],
  output ib_disp_pkg::slot_mask_t                      o_disp_rs1_valid,
  output ib_isa_pkg::reg_idx_t                         o_disp_rs1_idx [`IB_BLOCK_WORDS],
  output ib_disp_pkg::slot_mask_t                      o_disp_rs2_valid,
  output ib_isa_pkg::reg_idx_t                         o_disp_rs2_idx [`IB_BLOCK_WORDS],
  output ib_disp_pkg::pc_t                             o_disp_group_pc,
  output ib_disp_pkg::cnt_t                            o_disp_arith_cnt,
  output ib_disp_pkg::cnt_t                            o_disp_ld_cnt,
  output ib_disp_pkg::cnt_t                            o_disp_st_cnt,
  output ib_disp_pkg::cnt_t                            o_disp_br_cnt
);

  ib_disp_pkg::head_pos_t  r_head_pos;
  ib_disp_pkg::head_pos_t  w_word_idx [`IB_BLOCK_WORDS];
  ib_isa_pkg::inst_cat_t   w_slot_cat [`IB_BLOCK_WORDS];
  ib_disp_pkg::slot_mask_t w_remain;
  ib_disp_pkg::slot_mask_t w_group_mask;
  ib_disp_pkg::cnt_t       w_group_len;
  ib_disp_pkg::cnt_t       w_next_pos;
  logic                    w_fire;
  logic                    w_block_end;

  assign o_disp_valid = i_head_valid & ~i_flush_valid;
  assign w_fire       = o_disp_valid & i_disp_ready;

  // ------------------------------------------------------------------------
  // rotate head block so slot 0 is the first undispatched word
  // ------------------------------------------------------------------------
  for (genvar d = 0; d < `IB_BLOCK_WORDS; d++) begin : g_rotate
    assign w_word_idx[d] = r_head_pos + ib_disp_pkg::head_pos_t'(d);
    assign w_remain[d]   = (ib_disp_pkg::cnt_t'(r_head_pos) + ib_disp_pkg::cnt_t'(d)) <
                           ib_disp_pkg::cnt_t'(`IB_BLOCK_WORDS);
    assign w_slot_cat[d] = i_cat[w_word_idx[d]];
  end

  // longest prefix within the issue limits
  always_comb begin
    logic              run;
    ib_disp_pkg::cnt_t n_arith;
    ib_disp_pkg::cnt_t n_mem;
    ib_disp_pkg::cnt_t n_br;
    ib_disp_pkg::cnt_t n_ill;
    run     = o_disp_valid;
    n_arith = '0;
    n_mem   = '0;
    n_br    = '0;
    n_ill   = '0;
    for (int d = 0; d < `IB_BLOCK_WORDS; d++) begin
      n_arith = n_arith + ib_disp_pkg::cnt_t'(w_slot_cat[d] == ib_isa_pkg::CAT_ARITH);
      n_mem   = n_mem + ib_disp_pkg::cnt_t'((w_slot_cat[d] == ib_isa_pkg::CAT_LD) |
                                            (w_slot_cat[d] == ib_isa_pkg::CAT_ST));
      n_br    = n_br + ib_disp_pkg::cnt_t'(w_slot_cat[d] == ib_isa_pkg::CAT_BR);
      n_ill   = n_ill + ib_disp_pkg::cnt_t'(w_slot_cat[d] == ib_isa_pkg::CAT_ILL);
      run     = run & w_remain[d] & (n_arith <= `IB_ARITH_MAX) & (n_mem <= `IB_MEM_MAX) &
                (n_br <= `IB_BR_MAX) & (n_ill <= `IB_ILL_MAX);
      w_group_mask[d] = run;  // sticky low once a limit is crossed
    end
  end

  // ------------------------------------------------------------------------
  // resource counts and group length
  // ------------------------------------------------------------------------
  always_comb begin
    o_disp_arith_cnt = '0;
    o_disp_ld_cnt    = '0;
    o_disp_st_cnt    = '0;
    o_disp_br_cnt    = '0;
    w_group_len      = '0;
    for (int d = 0; d < `IB_BLOCK_WORDS; d++) begin
      if (w_group_mask[d]) begin
        w_group_len = w_group_len + ib_disp_pkg::cnt_t'(1);
        case (w_slot_cat[d])
          ib_isa_pkg::CAT_ARITH: o_disp_arith_cnt = o_disp_arith_cnt + ib_disp_pkg::cnt_t'(1);
          ib_isa_pkg::CAT_LD:    o_disp_ld_cnt    = o_disp_ld_cnt + ib_disp_pkg::cnt_t'(1);
          ib_isa_pkg::CAT_ST:    o_disp_st_cnt    = o_disp_st_cnt + ib_disp_pkg::cnt_t'(1);
          ib_isa_pkg::CAT_BR:    o_disp_br_cnt    = o_disp_br_cnt + ib_disp_pkg::cnt_t'(1);
          default:               ;  // illegal has no count output
        endcase
      end
    end
  end

  assign w_next_pos  = ib_disp_pkg::cnt_t'(r_head_pos) + w_group_len;
  assign w_block_end = w_next_pos >= ib_disp_pkg::cnt_t'(`IB_BLOCK_WORDS);
  assign o_pop       = w_fire & w_block_end;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head_pos <= '0;
    end else if (i_flush_valid) begin
      r_head_pos <= '0;
    end else if (w_fire) begin
      r_head_pos <= w_block_end ? '0 : ib_disp_pkg::head_pos_t'(w_next_pos);
    end
  end

  // ------------------------------------------------------------------------
  // slot outputs, zero outside the group
  // ------------------------------------------------------------------------
  assign o_disp_group_pc   = i_head_pc + ib_disp_pkg::pc_t'({r_head_pos, 2'b00});
  assign o_disp_slot_valid = w_group_mask;

  for (genvar d = 0; d < `IB_BLOCK_WORDS; d++) begin : g_slot
    logic w_on;
    assign w_on              = w_group_mask[d];
    assign o_disp_inst[d]    = w_on ? i_head_block[w_word_idx[d]] : '0;
    assign o_disp_pc[d]      = w_on ? o_disp_group_pc + ib_disp_pkg::pc_t'(4 * d) : '0;
    assign o_disp_cat[d]     = w_on ? w_slot_cat[d] : ib_isa_pkg::inst_cat_t'(0);
    assign o_disp_rd_valid[d]  = w_on & i_rd_valid[w_word_idx[d]];
    assign o_disp_rd_idx[d]    = w_on ? i_rd_idx[w_word_idx[d]] : '0;
    assign o_disp_rs1_valid[d] = w_on & i_rs1_valid[w_word_idx[d]];
    assign o_disp_rs1_idx[d]   = w_on ? i_rs1_idx[w_word_idx[d]] : '0;
    assign o_disp_rs2_valid[d] = w_on & i_rs2_valid[w_word_idx[d]];
    assign o_disp_rs2_idx[d]   = w_on ? i_rs2_idx[w_word_idx[d]] : '0;
  end

endmodule

/* hdl/ib_disp_pkg.sv */
package ib_disp_pkg;

`include "ib_defines.svh"

  typedef logic [31:0] pc_t;                              // byte address
  typedef logic [`IB_BLOCK_WORDS-1:0] slot_mask_t;        // one bit per slot
  typedef logic [$clog2(`IB_BLOCK_WORDS)-1:0] head_pos_t; // word in head block
  typedef logic [$clog2(`IB_BLOCK_WORDS):0] cnt_t;        // 0 up to block size
  typedef logic [$clog2(`IB_QUEUE_DEPTH)-1:0] q_ptr_t;

endpackage

/* hdl/ib_isa_pkg.sv */
package ib_isa_pkg;

  typedef logic [31:0] inst_word_t;
  typedef logic [4:0]  reg_idx_t;

  typedef enum logic [2:0] {
    CAT_ARITH,
    CAT_LD,
    CAT_ST,
    CAT_BR,
    CAT_ILL
  } inst_cat_t;

  // ----------------------------------------------------------------------
  // base opcodes, bits 6:0
  // ----------------------------------------------------------------------
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

endpackage

/* hdl/inst_buffer_top.sv */
`timescale 1ns/1ps

`include "ib_defines.svh"

module inst_buffer_top (
  input  logic                                         i_clk,
  input  logic                                         i_reset_n,
  input  logic                                         i_flush_valid,
  input  logic                                         i_inst_valid,
  input  ib_disp_pkg::pc_t                             i_inst_pc,
  input  ib_isa_pkg::inst_word_t [`IB_BLOCK_WORDS-1:0] i_inst_block,
  output logic                                         o_inst_ready,
  output logic                                         o_disp_valid,
  output ib_disp_pkg::slot_mask_t                      o_disp_slot_valid,
  output ib_isa_pkg::inst_word_t                       o_disp_inst    [`IB_BLOCK_WORDS],
  output ib_disp_pkg::pc_t                             o_disp_pc      [`IB_BLOCK_WORDS],
  output ib_isa_pkg::inst_cat_t                        o_disp_cat     [`IB_BLOCK_WORDS],
  output ib_disp_pkg::slot_mask_t                      o_disp_rd_valid,
  output ib_isa_pkg::reg_idx_t                         o_disp_rd_idx  [`IB_BLOCK_WORDS],
  output ib_disp_pkg::slot_mask_t                      o_disp_rs1_valid,
  output ib_isa_pkg::reg_idx_t                         o_disp_rs1_idx [`IB_BLOCK_WORDS],
  output ib_disp_pkg::slot_mask_t                      o_disp_rs2_valid,
  output ib_isa_pkg::reg_idx_t                         o_disp_rs2_idx [`IB_BLOCK_WORDS],
  output ib_disp_pkg::pc_t                             o_disp_group_pc,
  output ib_disp_pkg::cnt_t                            o_disp_arith_cnt,
  output ib_disp_pkg::cnt_t                            o_disp_ld_cnt,
  output ib_disp_pkg::cnt_t                            o_disp_st_cnt,
  output ib_disp_pkg::cnt_t                            o_disp_br_cnt,
  input  logic                                         i_disp_ready
);

  logic                                         w_pop;
  logic                                         w_head_valid;
  ib_disp_pkg::pc_t                             w_head_pc;
  ib_isa_pkg::inst_word_t [`IB_BLOCK_WORDS-1:0] w_head_block;
  ib_isa_pkg::inst_cat_t                        w_cat     [`IB_BLOCK_WORDS];
  ib_disp_pkg::slot_mask_t                      w_rd_valid;
  ib_disp_pkg::slot_mask_t                      w_rs1_valid;
  ib_disp_pkg::slot_mask_t                      w_rs2_valid;
  ib_isa_pkg::reg_idx_t                         w_rd_idx  [`IB_BLOCK_WORDS];
  ib_isa_pkg::reg_idx_t                         w_rs1_idx [`IB_BLOCK_WORDS];
  ib_isa_pkg::reg_idx_t                         w_rs2_idx [`IB_BLOCK_WORDS];

  inst_fetch_queue u_queue (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_flush_valid (i_flush_valid),
    .i_inst_valid  (i_inst_valid),
    .i_inst_pc     (i_inst_pc),
    .i_inst_block  (i_inst_block),
    .o_inst_ready  (o_inst_ready),
    .i_pop         (w_pop),
    .o_head_valid  (w_head_valid),
    .o_head_pc     (w_head_pc),
    .o_head_block  (w_head_block)
  );

  // one decoder per word of the head block
  for (genvar k = 0; k < `IB_BLOCK_WORDS; k++) begin : g_dec
    inst_slot_decoder u_dec (
      .i_inst      (w_head_block[k]),
      .o_cat       (w_cat[k]),
      .o_rd_valid  (w_rd_valid[k]),
      .o_rd_idx    (w_rd_idx[k]),
      .o_rs1_valid (w_rs1_valid[k]),
      .o_rs1_idx   (w_rs1_idx[k]),
      .o_rs2_valid (w_rs2_valid[k]),
      .o_rs2_idx   (w_rs2_idx[k])
    );
  end

  dispatch_group_picker u_picker (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_flush_valid     (i_flush_valid),
    .i_head_valid      (w_head_valid),
    .i_head_pc         (w_head_pc),
    .i_head_block      (w_head_block),
    .i_cat             (w_cat),
    .i_rd_valid        (w_rd_valid),
    .i_rd_idx          (w_rd_idx),
    .i_rs1_valid       (w_rs1_valid),
    .i_rs1_idx         (w_rs1_idx),
    .i_rs2_valid       (w_rs2_valid),
    .i_rs2_idx         (w_rs2_idx),
    .i_disp_ready      (i_disp_ready),
    .o_pop             (w_pop),
    .o_disp_valid      (o_disp_valid),
    .o_disp_slot_valid (o_disp_slot_valid),
    .o_disp_inst       (o_disp_inst),
    .o_disp_pc         (o_disp_pc),
    .o_disp_cat        (o_disp_cat),
    .o_disp_rd_valid   (o_disp_rd_valid),
    .o_disp_rd_idx     (o_disp_rd_idx),
    .o_disp_rs1_valid  (o_disp_rs1_valid),
    .o_disp_rs1_idx    (o_disp_rs1_idx),
    .o_disp_rs2_valid  (o_disp_rs2_valid),
    .o_disp_rs2_idx    (o_disp_rs2_idx),
    .o_disp_group_pc   (o_disp_group_pc),
    .o_disp_arith_cnt  (o_disp_arith_cnt),
    .o_disp_ld_cnt     (o_disp_ld_cnt),
    .o_disp_st_cnt     (o_disp_st_cnt),
    .o_disp_br_cnt     (o_disp_br_cnt)
  );

endmodule

/* hdl/inst_fetch_queue.sv */
`timescale 1ns/1ps

`include "ib_defines.svh"

module inst_fetch_queue (
  input  logic                                         i_clk,
  input  logic                                         i_reset_n,
  input  logic                                         i_flush_valid,
  input  logic                                         i_inst_valid,
  input  ib_disp_pkg::pc_t                             i_inst_pc,
  input  ib_isa_pkg::inst_word_t [`IB_BLOCK_WORDS-1:0] i_inst_block,
  output logic                                         o_inst_ready,
  input  logic                                         i_pop,
  output logic                                         o_head_valid,
  output ib_disp_pkg::pc_t                             o_head_pc,
  output ib_isa_pkg::inst_word_t [`IB_BLOCK_WORDS-1:0] o_head_block
);

  logic [`IB_QUEUE_DEPTH-1:0]                   r_valid;
  ib_disp_pkg::pc_t                             r_pc    [`IB_QUEUE_DEPTH];
  ib_isa_pkg::inst_word_t [`IB_BLOCK_WORDS-1:0] r_block [`IB_QUEUE_DEPTH];
  ib_disp_pkg::q_ptr_t                          r_in_ptr;
  ib_disp_pkg::q_ptr_t                          r_out_ptr;
  logic                                         w_push;
  logic                                         w_pop;

  assign o_inst_ready = ~(&r_valid) & ~i_flush_valid;  // full stalls fetch
  assign w_push       = i_inst_valid & o_inst_ready;
  assign w_pop        = i_pop & r_valid[r_out_ptr];

  // ------------------------------------------------------------------------
  // entry valid bits and pointers
  // ------------------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid   <= '0;
      r_in_ptr  <= '0;
      r_out_ptr <= '0;
    end else if (i_flush_valid) begin
      r_valid   <= '0;
      r_in_ptr  <= '0;
      r_out_ptr <= '0;
    end else begin
      if (w_push) begin
        r_valid[r_in_ptr] <= 1'b1;
        r_in_ptr          <= r_in_ptr + ib_disp_pkg::q_ptr_t'(1);
      end
      if (w_pop) begin
        r_valid[r_out_ptr] <= 1'b0;     // never the entry being written
        r_out_ptr          <= r_out_ptr + ib_disp_pkg::q_ptr_t'(1);
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_push) begin
      r_pc[r_in_ptr]    <= i_inst_pc;
      r_block[r_in_ptr] <= i_inst_block;
    end
  end

  assign o_head_valid = r_valid[r_out_ptr];
  assign o_head_pc    = r_pc[r_out_ptr];
  assign o_head_block = r_block[r_out_ptr];

endmodule

/* hdl/inst_slot_decoder.sv */
`timescale 1ns/1ps

module inst_slot_decoder (
  input  ib_isa_pkg::inst_word_t i_inst,
  output ib_isa_pkg::inst_cat_t  o_cat,
  output logic                   o_rd_valid,
  output ib_isa_pkg::reg_idx_t   o_rd_idx,
  output logic                   o_rs1_valid,
  output ib_isa_pkg::reg_idx_t   o_rs1_idx,
  output logic                   o_rs2_valid,
  output ib_isa_pkg::reg_idx_t   o_rs2_idx
);

  logic [6:0] w_opc;

  assign w_opc = i_inst[6:0];

  always_comb begin
    o_cat       = ib_isa_pkg::CAT_ILL;
    o_rd_valid  = 1'b0;
    o_rs1_valid = 1'b0;
    o_rs2_valid = 1'b0;
    if (i_inst[1:0] == 2'b11) begin  // 16-bit encodings stay illegal
      case (w_opc)
        ib_isa_pkg::OPC_OP: begin
          o_cat       = ib_isa_pkg::CAT_ARITH;
          o_rd_valid  = 1'b1;
          o_rs1_valid = 1'b1;
          o_rs2_valid = 1'b1;
        end
        ib_isa_pkg::OPC_OP_IMM: begin
          o_cat       = ib_isa_pkg::CAT_ARITH;
          o_rd_valid  = 1'b1;
          o_rs1_valid = 1'b1;
        end
        ib_isa_pkg::OPC_LUI, ib_isa_pkg::OPC_AUIPC: begin
          o_cat      = ib_isa_pkg::CAT_ARITH;
          o_rd_valid = 1'b1;
        end
        ib_isa_pkg::OPC_LOAD: begin
          o_cat       = ib_isa_pkg::CAT_LD;
          o_rd_valid  = 1'b1;
          o_rs1_valid = 1'b1;
        end
        ib_isa_pkg::OPC_STORE, ib_isa_pkg::OPC_BRANCH: begin
          o_cat = (w_opc == ib_isa_pkg::OPC_STORE) ? ib_isa_pkg::CAT_ST :
                                                     ib_isa_pkg::CAT_BR;
          o_rs1_valid = 1'b1;
          o_rs2_valid = 1'b1;
        end
        ib_isa_pkg::OPC_JAL: begin
          o_cat      = ib_isa_pkg::CAT_BR;
          o_rd_valid = 1'b1;
        end
        ib_isa_pkg::OPC_JALR: begin
          o_cat       = ib_isa_pkg::CAT_BR;
          o_rd_valid  = 1'b1;
          o_rs1_valid = 1'b1;
        end
        default: o_cat = ib_isa_pkg::CAT_ILL;  // SYSTEM, FENCE, unknown
      endcase
    end
  end

  assign o_rd_idx  = o_rd_valid  ? i_inst[11:7]  : '0;
  assign o_rs1_idx = o_rs1_valid ? i_inst[19:15] : '0;
  assign o_rs2_idx = o_rs2_valid ? i_inst[24:20] : '0;

endmodule

/* include/ib_defines.svh */
`ifndef IB_DEFINES_SVH
`define IB_DEFINES_SVH

// ------------------------------------------------------------------------
// buffer geometry
// ------------------------------------------------------------------------
`define IB_BLOCK_WORDS 4  // words per fetch block, also dispatch slots
`define IB_QUEUE_DEPTH 4  // fetch blocks held

// ------------------------------------------------------------------------
// per-group issue limits
// ------------------------------------------------------------------------
`define IB_ARITH_MAX 4
`define IB_MEM_MAX   2    // loads and stores together
`define IB_BR_MAX    1
`define IB_ILL_MAX   1

`endif

/* sim/inst_buffer_properties.sv */
`timescale 1ns/1ps

module inst_buffer_properties (
  input logic                    i_clk,
  input logic                    i_reset_n,
  input logic                    i_flush_valid,
  input logic                    i_disp_ready,
  input logic                    o_disp_valid,
  input ib_disp_pkg::slot_mask_t o_disp_slot_valid,
  input ib_disp_pkg::pc_t        o_disp_group_pc,
  input ib_disp_pkg::cnt_t       o_disp_arith_cnt,
  input ib_disp_pkg::cnt_t       o_disp_ld_cnt,
  input ib_disp_pkg::cnt_t       o_disp_st_cnt,
  input ib_disp_pkg::cnt_t       o_disp_br_cnt
);

  a_idle_after_reset: assert property (@(posedge i_clk)
    $rose(i_reset_n) |-> !o_disp_valid)
    else $error("dispatch valid high in the cycle after reset");

  a_br_limit: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_disp_br_cnt <= 1)
    else $error("more than one branch in a group");

  // group held under back-pressure unless flushed
  a_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (o_disp_valid && !i_disp_ready) |=> (i_flush_valid ||
      (o_disp_valid &&
       $stable(o_disp_slot_valid) && $stable(o_disp_group_pc) &&
       $stable(o_disp_arith_cnt) && $stable(o_disp_ld_cnt) &&
       $stable(o_disp_st_cnt) && $stable(o_disp_br_cnt))))
    else $error("dispatch group changed while stalled");

  a_flush_quiet: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_flush_valid |-> !o_disp_valid)
    else $error("dispatch valid high during a flush");

endmodule

bind inst_buffer_top inst_buffer_properties u_props (
  .i_clk             (i_clk),
  .i_reset_n         (i_reset_n),
  .i_flush_valid     (i_flush_valid),
  .i_disp_ready      (i_disp_ready),
  .o_disp_valid      (o_disp_valid),
  .o_disp_slot_valid (o_disp_slot_valid),
  .o_disp_group_pc   (o_disp_group_pc),
  .o_disp_arith_cnt  (o_disp_arith_cnt),
  .o_disp_ld_cnt     (o_disp_ld_cnt),
  .o_disp_st_cnt     (o_disp_st_cnt),
  .o_disp_br_cnt     (o_disp_br_cnt)
);

/* sim/tb_inst_buffer.sv */
`timescale 1ns/1ps

`include "ib_defines.svh"

module tb_inst_buffer;

  localparam int ROWS       = 10;
  localparam int W          = `IB_BLOCK_WORDS;

  logic                                 i_clk;
  logic                                 i_reset_n;
  logic                                 i_flush_valid;
  logic                                 i_inst_valid;
  ib_disp_pkg::pc_t                     i_inst_pc;
  ib_isa_pkg::inst_word_t [W-1:0]       i_inst_block;
  logic                                 o_inst_ready;
  logic                                 o_disp_valid;
  ib_disp_pkg::slot_mask_t              o_disp_slot_valid;
  ib_isa_pkg::inst_word_t               o_disp_inst    [W];
  ib_disp_pkg::pc_t                     o_disp_pc      [W];
  ib_isa_pkg::inst_cat_t                o_disp_cat     [W];
  ib_disp_pkg::slot_mask_t              o_disp_rd_valid;
  ib_isa_pkg::reg_idx_t                 o_disp_rd_idx  [W];
  ib_disp_pkg::slot_mask_t              o_disp_rs1_valid;
  ib_isa_pkg::reg_idx_t                 o_disp_rs1_idx [W];
  ib_disp_pkg::slot_mask_t              o_disp_rs2_valid;
  ib_isa_pkg::reg_idx_t                 o_disp_rs2_idx [W];
  ib_disp_pkg::pc_t                     o_disp_group_pc;
  ib_disp_pkg::cnt_t                    o_disp_arith_cnt;
  ib_disp_pkg::cnt_t                    o_disp_ld_cnt;
  ib_disp_pkg::cnt_t                    o_disp_st_cnt;
  ib_disp_pkg::cnt_t                    o_disp_br_cnt;
  logic                                 i_disp_ready;

  // stimulus table
  ib_disp_pkg::pc_t       tbl_pc     [ROWS];
  ib_isa_pkg::inst_word_t tbl_w      [ROWS][W];
  int                     tbl_groups [ROWS];

  // reference model state
  int mq[$];
  int m_pos;
  int m_groups;
  int feed_idx;
  int feed_end;
  bit accepted;
  bit rand_mode;
  bit fixed_ready;
  bit flush_req;

  // expected group
  ib_disp_pkg::slot_mask_t e_mask;
  ib_isa_pkg::inst_word_t  e_inst [W];
  ib_disp_pkg::pc_t        e_pc   [W];
  ib_isa_pkg::inst_cat_t   e_cat  [W];
  ib_disp_pkg::slot_mask_t e_rdv, e_r1v, e_r2v;
  ib_isa_pkg::reg_idx_t    e_rd [W], e_rs1 [W], e_rs2 [W];
  int                      e_ar, e_ld, e_st, e_br, e_len;

  inst_buffer_top DUT (.*);

  always #10 i_clk = ~i_clk;

  initial begin
    #(ROWS * 40 * 20);
    $display("Simulation timed out before all blocks were dispatched");
    $display("Verification failed");
    $fatal(1);
  end

  function automatic ib_isa_pkg::inst_word_t encode(logic [6:0] opc, int rd, int rs1, int rs2);
    return {7'h00, 5'(rs2), 5'(rs1), 3'b000, 5'(rd), opc};
  endfunction

  task automatic set_row(input int r, input ib_isa_pkg::inst_word_t w0, w1, w2, w3,
                         input int groups);
    tbl_pc[r]     = 32'h0000_1000 + 32'(r * 16);
    tbl_w[r][0]   = w0;
    tbl_w[r][1]   = w1;
    tbl_w[r][2]   = w2;
    tbl_w[r][3]   = w3;
    tbl_groups[r] = groups;
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp) else begin
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("Verification failed");
      $fatal(1);
    end
  endtask

  // category and register usage from the opcode rules
  task automatic classify(input ib_isa_pkg::inst_word_t w, output ib_isa_pkg::inst_cat_t c,
                          output logic rdv, output logic r1v, output logic r2v);
    logic [6:0] opc;
    opc = w[6:0];
    c   = ib_isa_pkg::CAT_ILL;
    if (w[1:0] == 2'b11) begin
      case (opc)
        ib_isa_pkg::OPC_OP, ib_isa_pkg::OPC_OP_IMM,
        ib_isa_pkg::OPC_LUI, ib_isa_pkg::OPC_AUIPC:  c = ib_isa_pkg::CAT_ARITH;
        ib_isa_pkg::OPC_LOAD:                        c = ib_isa_pkg::CAT_LD;
        ib_isa_pkg::OPC_STORE:                       c = ib_isa_pkg::CAT_ST;
        ib_isa_pkg::OPC_BRANCH, ib_isa_pkg::OPC_JAL,
        ib_isa_pkg::OPC_JALR:                        c = ib_isa_pkg::CAT_BR;
        default:                                     c = ib_isa_pkg::CAT_ILL;
      endcase
    end
    rdv = (c == ib_isa_pkg::CAT_ARITH) || (c == ib_isa_pkg::CAT_LD) ||
          (c != ib_isa_pkg::CAT_ILL &&
           (opc == ib_isa_pkg::OPC_JAL || opc == ib_isa_pkg::OPC_JALR));
    r1v = (c != ib_isa_pkg::CAT_ILL) && opc != ib_isa_pkg::OPC_LUI &&
          opc != ib_isa_pkg::OPC_AUIPC && opc != ib_isa_pkg::OPC_JAL;
    r2v = (c != ib_isa_pkg::CAT_ILL) &&
          (opc == ib_isa_pkg::OPC_OP || opc == ib_isa_pkg::OPC_STORE ||
           opc == ib_isa_pkg::OPC_BRANCH);
  endtask

  task automatic build_expected(input int row, input int pos);
    int                     n_ar, n_mem, n_br, n_ill;
    bit                     run;
    ib_isa_pkg::inst_word_t w;
    ib_isa_pkg::inst_cat_t  c;
    logic                   rdv, r1v, r2v;
    run    = 1;
    n_ar   = 0;
    n_mem  = 0;
    n_br   = 0;
    n_ill  = 0;
    e_mask = '0;
    e_rdv  = '0;
    e_r1v  = '0;
    e_r2v  = '0;
    e_ar   = 0;
    e_ld   = 0;
    e_st   = 0;
    e_br   = 0;
    e_len  = 0;
    for (int d = 0; d < W; d++) begin
      e_inst[d] = '0;
      e_pc[d]   = '0;
      e_cat[d]  = ib_isa_pkg::inst_cat_t'(0);
      e_rd[d]   = '0;
      e_rs1[d]  = '0;
      e_rs2[d]  = '0;
      if (run && pos + d < W) begin
        w = tbl_w[row][pos + d];
        classify(w, c, rdv, r1v, r2v);
        n_ar  += (c == ib_isa_pkg::CAT_ARITH);
        n_mem += (c == ib_isa_pkg::CAT_LD || c == ib_isa_pkg::CAT_ST);
        n_br  += (c == ib_isa_pkg::CAT_BR);
        n_ill += (c == ib_isa_pkg::CAT_ILL);
        if (n_ar > `IB_ARITH_MAX || n_mem > `IB_MEM_MAX || n_br > `IB_BR_MAX ||
            n_ill > `IB_ILL_MAX) begin
          run = 0;
        end else begin
          e_mask[d] = 1;
          e_len++;
          e_inst[d] = w;
          e_pc[d]   = tbl_pc[row] + 32'(4 * (pos + d));
          e_cat[d]  = c;
          e_rdv[d]  = rdv;
          e_r1v[d]  = r1v;
          e_r2v[d]  = r2v;
          e_rd[d]   = rdv ? w[11:7] : '0;
          e_rs1[d]  = r1v ? w[19:15] : '0;
          e_rs2[d]  = r2v ? w[24:20] : '0;
          e_ar += (c == ib_isa_pkg::CAT_ARITH);
          e_ld += (c == ib_isa_pkg::CAT_LD);
          e_st += (c == ib_isa_pkg::CAT_ST);
          e_br += (c == ib_isa_pkg::CAT_BR);
        end
      end
    end
  endtask

  task automatic check_group();
    int row;
    row = mq[0];
    build_expected(row, m_pos);
    check_eq(o_disp_slot_valid, e_mask, $sformatf("row %0d pos %0d slot mask", row, m_pos));
    check_eq(o_disp_group_pc, tbl_pc[row] + 32'(4 * m_pos), "group pc");
    check_eq(o_disp_arith_cnt, e_ar, "arith count");
    check_eq(o_disp_ld_cnt, e_ld, "load count");
    check_eq(o_disp_st_cnt, e_st, "store count");
    check_eq(o_disp_br_cnt, e_br, "branch count");
    check_eq(o_disp_rd_valid, e_rdv, "rd valid mask");
    check_eq(o_disp_rs1_valid, e_r1v, "rs1 valid mask");
    check_eq(o_disp_rs2_valid, e_r2v, "rs2 valid mask");
    for (int d = 0; d < W; d++) begin
      check_eq(o_disp_inst[d], e_inst[d], $sformatf("slot %0d inst", d));
      check_eq(o_disp_pc[d], e_pc[d], $sformatf("slot %0d pc", d));
      check_eq(o_disp_cat[d], e_cat[d], $sformatf("slot %0d category", d));
      check_eq(o_disp_rd_idx[d], e_rd[d], $sformatf("slot %0d rd", d));
      check_eq(o_disp_rs1_idx[d], e_rs1[d], $sformatf("slot %0d rs1", d));
      check_eq(o_disp_rs2_idx[d], e_rs2[d], $sformatf("slot %0d rs2", d));
    end
  endtask

  // ------------------------------------------------------------------------
  // check at the falling edge and drive after the rising edge
  // ------------------------------------------------------------------------
  task automatic run_cycle();
    @(negedge i_clk);
    if (i_flush_valid) begin
      check_eq(o_disp_valid, 0, "dispatch valid in flush");
      check_eq(o_inst_ready, 0, "fetch ready in flush");
      mq.delete();
      m_pos    = 0;
      m_groups = 0;
      accepted = 0;
    end else begin
      check_eq(o_inst_ready, mq.size() < `IB_QUEUE_DEPTH, "fetch ready");
      check_eq(o_disp_valid, mq.size() > 0, "dispatch valid");
      if (o_disp_valid) begin
        check_group();
      end else begin
        check_eq(o_disp_slot_valid, 0, "slot mask while idle");
      end
      if (o_disp_valid && i_disp_ready) begin
        m_groups++;
        m_pos += e_len;
        if (m_pos >= W) begin
          check_eq(m_groups, tbl_groups[mq[0]], $sformatf("groups of row %0d", mq[0]));
          void'(mq.pop_front());
          m_pos    = 0;
          m_groups = 0;
        end
      end
      if (i_inst_valid && o_inst_ready) begin
        mq.push_back(feed_idx);
        accepted = 1;
      end
    end
    @(posedge i_clk);
    #1;
    if (accepted) feed_idx++;
    accepted      = 0;
    i_flush_valid = flush_req;
    i_inst_valid  = !flush_req && feed_idx < feed_end;
    if (feed_idx < feed_end) begin
      i_inst_pc = tbl_pc[feed_idx % ROWS];
      for (int k = 0; k < W; k++) i_inst_block[k] = tbl_w[feed_idx % ROWS][k];
    end
    i_disp_ready = rand_mode ? (($urandom % 100) < 70) : fixed_ready;
  endtask

  initial begin
    i_clk         = 0;
    i_reset_n     = 0;
    i_flush_valid = 0;
    i_inst_valid  = 0;
    i_inst_pc     = '0;
    i_inst_block  = '0;
    i_disp_ready  = 0;
    m_pos         = 0;
    m_groups      = 0;
    accepted      = 0;
    flush_req     = 0;
    void'($urandom(32'h49e0));
    set_row(0, encode(ib_isa_pkg::OPC_OP, 1, 2, 3), encode(ib_isa_pkg::OPC_OP_IMM, 4, 5, 0),
            encode(ib_isa_pkg::OPC_LUI, 6, 0, 0), encode(ib_isa_pkg::OPC_AUIPC, 7, 0, 0), 1);
    set_row(1, encode(ib_isa_pkg::OPC_LOAD, 8, 9, 0), encode(ib_isa_pkg::OPC_LOAD, 10, 11, 0),
            encode(ib_isa_pkg::OPC_LOAD, 12, 13, 0), encode(ib_isa_pkg::OPC_OP, 14, 15, 16), 2);
    set_row(2, encode(ib_isa_pkg::OPC_BRANCH, 0, 1, 2), encode(ib_isa_pkg::OPC_BRANCH, 0, 3, 4),
            encode(ib_isa_pkg::OPC_OP, 5, 6, 7), encode(ib_isa_pkg::OPC_OP, 8, 9, 10), 2);
    set_row(3, encode(ib_isa_pkg::OPC_OP, 17, 18, 19), 32'h0000_0000,
            32'hffff_ffff, encode(ib_isa_pkg::OPC_OP, 20, 21, 22), 2);
    set_row(4, encode(ib_isa_pkg::OPC_STORE, 0, 23, 24), encode(ib_isa_pkg::OPC_LOAD, 25, 26, 0),
            encode(ib_isa_pkg::OPC_JAL, 1, 0, 0), encode(ib_isa_pkg::OPC_JALR, 2, 3, 0), 2);
    set_row(5, encode(ib_isa_pkg::OPC_BRANCH, 0, 4, 5), encode(ib_isa_pkg::OPC_JAL, 6, 0, 0),
            encode(ib_isa_pkg::OPC_JALR, 7, 8, 0), encode(ib_isa_pkg::OPC_BRANCH, 0, 9, 10), 4);
    set_row(6, 32'h0000_0073, encode(ib_isa_pkg::OPC_OP, 11, 12, 13),
            32'h0000_4501, encode(ib_isa_pkg::OPC_OP, 14, 15, 16), 2);
    set_row(7, encode(ib_isa_pkg::OPC_LOAD, 27, 28, 0), encode(ib_isa_pkg::OPC_STORE, 0, 29, 30),
            encode(ib_isa_pkg::OPC_STORE, 0, 31, 1), encode(ib_isa_pkg::OPC_LOAD, 2, 3, 0), 2);
    set_row(8, encode(ib_isa_pkg::OPC_OP_IMM, 1, 2, 0), encode(ib_isa_pkg::OPC_OP_IMM, 3, 4, 0),
            encode(ib_isa_pkg::OPC_OP_IMM, 5, 6, 0), encode(ib_isa_pkg::OPC_OP_IMM, 7, 8, 0), 1);
    set_row(9, encode(ib_isa_pkg::OPC_LOAD, 9, 10, 0), encode(ib_isa_pkg::OPC_OP, 11, 12, 13),
            encode(ib_isa_pkg::OPC_STORE, 0, 14, 15), encode(ib_isa_pkg::OPC_BRANCH, 0, 16, 17), 1);
    repeat (2) @(posedge i_clk);
    #1;
    i_reset_n = 1;

    // whole table under random back-pressure
    feed_idx  = 0;
    feed_end  = ROWS;
    rand_mode = 1;
    while (!(feed_idx >= feed_end && mq.size() == 0)) run_cycle();

    // fill the queue while stalled, dispatch one group, then flush
    feed_idx    = 1;
    feed_end    = 7;
    rand_mode   = 0;
    fixed_ready = 0;
    repeat (8) run_cycle();
    fixed_ready = 1;
    run_cycle();
    fixed_ready = 0;
    flush_req   = 1;
    feed_end    = feed_idx;
    run_cycle();
    flush_req = 0;
    repeat (3) run_cycle();

    // restart from word 0 after the flush
    feed_idx  = 0;
    feed_end  = ROWS;
    rand_mode = 1;
    while (!(feed_idx >= feed_end && mq.size() == 0)) run_cycle();

    $display("Verification passed");
    $finish;
  end

endmodule
